// ==== source/gpio_defines.svh ====
// Bank geometry, bus widths and register map macros
// for the J/K GPIO port bank
`ifndef GPIO_DEFINES_SVH
`define GPIO_DEFINES_SVH

// ----------------------------------------------------------------------
// Bank geometry
// ----------------------------------------------------------------------
`define GPIO_NUM_PORTS        8   // J0..J3, then K0..K3
`define GPIO_PORTS_PER_GROUP  4   // Ports sharing one pcint line
`define GPIO_NUM_GROUPS       2   // Group J on bit 0, group K on bit 1
`define GPIO_PORT_WIDTH       8   // Pins per port

// Data-memory bus
`define GPIO_ADDR_WIDTH       8
`define GPIO_DATA_WIDTH       8

// ----------------------------------------------------------------------
// Register map
// ----------------------------------------------------------------------
// J0 PIN register, each port takes four addresses after it
`define GPIO_BASE_ADDR        8'h90

// Offsets inside one port
`define GPIO_REG_PIN          2'd0   // Pad inputs, write toggles PORT
`define GPIO_REG_DDR          2'd1   // Direction, 1 = drive
`define GPIO_REG_PORT         2'd2   // Output value
`define GPIO_REG_MSK          2'd3   // Pin change mask

`endif

// ==== source/gpio_pkg.sv ====
// Shared vector typedefs and bundle structs for the GPIO bank
`default_nettype none
`include "gpio_defines.svh"

package gpio_pkg;

   // Plain vectors
   typedef logic [`GPIO_ADDR_WIDTH-1:0] addr_t;     // Data-memory address
   typedef logic [`GPIO_DATA_WIDTH-1:0] data_t;     // Bus data
   typedef logic [`GPIO_PORT_WIDTH-1:0] pin_vec_t;  // One port's pins
   typedef logic [`GPIO_NUM_PORTS-1:0]  port_sel_t; // One-hot port pick
   typedef logic [1:0]                  reg_kind_t; // PIN/DDR/PORT/MSK

   // Data-memory access from the CPU
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  re;     // Read strobe, one cycle
      logic  we;     // Write strobe, one cycle
      logic  sel;    // Data-memory select
   } dm_bus_t;

   // Decoded access, fanned out to all ports
   typedef struct packed {
      port_sel_t wr;
      port_sel_t rd;
      reg_kind_t kind;
   } reg_strobe_t;

   // Crossbar override per pin
   typedef struct packed {
      pin_vec_t ddoe;   // Direction override enable
      pin_vec_t ddov;   // Direction override value
      pin_vec_t pvoe;   // Output value override enable
      pin_vec_t pvov;   // Output value override
   } xb_ctl_t;

   typedef struct packed {
      pin_vec_t portx;
      pin_vec_t ddrx;
   } port_drive_t;

   // What actually reaches the pads
   typedef struct packed {
      pin_vec_t out;
      pin_vec_t oe;
   } pad_drive_t;

endpackage
`default_nettype wire

// ==== source/gpio_reg_decode.sv ====
// Data-memory address decoder for the port bank
// Turns one bus access into per-port strobes plus a register kind
`timescale 1ns/1ns
`default_nettype none
`include "gpio_defines.svh"

module gpio_reg_decode (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire gpio_pkg::dm_bus_t     dm,
   output gpio_pkg::reg_strobe_t      strobe
);

   // ----------------------------------------------------------------------
   // Map geometry
   // ----------------------------------------------------------------------
   localparam int KIND_W        = $bits(gpio_pkg::reg_kind_t);
   localparam int REGS_PER_PORT = 1 << KIND_W;            // 4 regs per port
   localparam int IDX_W         = $clog2(`GPIO_NUM_PORTS);

   // Last mapped address, 8'hAF for eight ports
   localparam gpio_pkg::addr_t MAP_LAST =
      gpio_pkg::addr_t'(`GPIO_BASE_ADDR + REGS_PER_PORT * `GPIO_NUM_PORTS - 1);

   gpio_pkg::addr_t     offset;     // Address relative to J0 PIN
   logic [IDX_W-1:0]    port_idx;
   logic                in_map;
   gpio_pkg::port_sel_t port_hit;   // One-hot, zero when off map

   assign offset   = dm.addr - `GPIO_BASE_ADDR;
   assign port_idx = offset[KIND_W +: IDX_W];  // offset / 4

   // Select must be up and the address inside the window
   assign in_map = dm.sel &&
                   (dm.addr >= `GPIO_BASE_ADDR) &&
                   (dm.addr <= MAP_LAST);

   always_comb begin
      port_hit = '0;
      if (in_map) begin
         port_hit[port_idx] = 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // Strobes out
   // ----------------------------------------------------------------------
   always_comb begin
      strobe.wr   = dm.we ? port_hit : '0;
      strobe.rd   = dm.re ? port_hit : '0;
      strobe.kind = offset[KIND_W-1:0];     // Low two bits pick the register
   end

   // CPU never reads and writes in the same cycle
   a_no_rd_and_wr: assert property (
      @(posedge clk) disable iff (reset)
      !(dm.re && dm.we)
   ) else $error("gpio_reg_decode: re and we both high");

endmodule
`default_nettype wire

// ==== source/gpio_port_regs.sv ====
// One 8-pin port: DDR, PORT and MSK registers, PIN toggle,
// two-stage pad synchroniser and pin change detector
`timescale 1ns/1ns
`default_nettype none
`include "gpio_defines.svh"

module gpio_port_regs (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  wr,        // Write to this port
   input  wire logic                  rd,        // Read from this port
   input  wire gpio_pkg::reg_kind_t   kind,
   input  wire gpio_pkg::data_t       wdata,
   input  wire gpio_pkg::pin_vec_t    pad_in,
   output gpio_pkg::port_drive_t      drive,
   output gpio_pkg::pin_vec_t         pinx,
   output gpio_pkg::data_t            rdata,
   output logic                       pcifr_set
);

   // Software visible state
   gpio_pkg::pin_vec_t ddr_q;
   gpio_pkg::pin_vec_t port_q;
   gpio_pkg::pin_vec_t msk_q;

   // Pad sampling chain
   gpio_pkg::pin_vec_t pin_meta;   // First stage, may go metastable
   gpio_pkg::pin_vec_t pin_sync;   // Second stage, the PIN value
   gpio_pkg::pin_vec_t pin_prev;   // One sample older than pin_sync
   gpio_pkg::pin_vec_t pin_delta;  // Masked changed bits

   // ----------------------------------------------------------------------
   // Register writes
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         ddr_q  <= '0;
         port_q <= '0;
         msk_q  <= '0;
      end else if (wr) begin
         case (kind)
            `GPIO_REG_PIN:  port_q <= port_q ^ wdata; // Ones flip PORT bits
            `GPIO_REG_DDR:  ddr_q  <= wdata;
            `GPIO_REG_PORT: port_q <= wdata;
            `GPIO_REG_MSK:  msk_q  <= wdata;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // Pad synchroniser
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         pin_meta <= '0;
         pin_sync <= '0;
         pin_prev <= '0;
      end else begin
         pin_meta <= pad_in;     // Edge k
         pin_sync <= pin_meta;   // Edge k+1
         pin_prev <= pin_sync;   // Edge k+2
      end
   end

   // Only unmasked-out pins count
   assign pin_delta = (pin_prev ^ pin_sync) & msk_q;

   // One-cycle flag after edge k+2
   always_ff @(posedge clk) begin
      if (reset) begin
         pcifr_set <= 1'b0;
      end else begin
         pcifr_set <= |pin_delta;
      end
   end

   // ----------------------------------------------------------------------
   // Read data and outputs
   // ----------------------------------------------------------------------
   always_comb begin
      rdata = '0;
      if (rd) begin
         case (kind)
            `GPIO_REG_PIN:  rdata = pin_sync;
            `GPIO_REG_DDR:  rdata = ddr_q;
            `GPIO_REG_PORT: rdata = port_q;
            `GPIO_REG_MSK:  rdata = msk_q;
         endcase
      end
   end

   always_comb begin
      drive.portx = port_q;
      drive.ddrx  = ddr_q;
   end

   assign pinx = pin_sync;   // Back to the crossbar

   // Back-to-back flags need the synchronised pins to move on each of
   // the two cycles before
   a_pcifr_single: assert property (
      @(posedge clk) disable iff (reset)
      (pcifr_set && $past(pcifr_set)) |->
         ($past(pin_sync, 1) != $past(pin_sync, 2)) &&
         ($past(pin_sync, 2) != $past(pin_sync, 3))
   ) else $error("gpio_port_regs: pcifr_set held without new pin change");

endmodule
`default_nettype wire

// ==== source/gpio_pin_mux.sv ====
// Pad control for one port
// Crossbar override or register control, chosen per pin
`timescale 1ns/1ns
`default_nettype none

module gpio_pin_mux (
   input  wire gpio_pkg::port_drive_t port,   // From the port registers
   input  wire gpio_pkg::xb_ctl_t     xb,     // Crossbar override
   output gpio_pkg::pad_drive_t       pad
);

   gpio_pkg::pin_vec_t dir;   // 1 = pin drives
   gpio_pkg::pin_vec_t val;   // Value put on the pin

   // ----------------------------------------------------------------------
   // Per-bit selection
   // ----------------------------------------------------------------------
   // Direction, crossbar wins where ddoe is set
   assign dir = (xb.ddoe & xb.ddov) | (~xb.ddoe & port.ddrx);

   // Output value, crossbar wins where pvoe is set
   assign val = (xb.pvoe & xb.pvov) | (~xb.pvoe & port.portx);

   always_comb begin
      pad.out = val;
      pad.oe  = dir;   // Pad tristates where this is 0
   end

endmodule
`default_nettype wire

// ==== source/gpio_readback.sv ====
// Read data return path for the port bank
// Picks the addressed port's byte and raises the output enable
`timescale 1ns/1ns
`default_nettype none
`include "gpio_defines.svh"

module gpio_readback (
   input  wire gpio_pkg::port_sel_t   rd,                       // One-hot read
   input  wire gpio_pkg::data_t       rdata [`GPIO_NUM_PORTS],  // Per-port data
   output gpio_pkg::data_t            dbus_out,
   output logic                       io_out_en
);

   // ----------------------------------------------------------------------
   // Data select
   // ----------------------------------------------------------------------
   // OR of the selected port only, zero when nothing is read
   always_comb begin
      dbus_out = '0;
      for (int i = 0; i < `GPIO_NUM_PORTS; i++) begin
         if (rd[i]) begin
            dbus_out = dbus_out | rdata[i];
         end
      end
   end

   // Any mapped read drives the bus
   assign io_out_en = |rd;

   // Decoder must address a single port at most
   a_rd_onehot: assert final ($onehot0(rd))
      else $error("gpio_readback: more than one port read at once");

endmodule
`default_nettype wire

// ==== source/gpio_bank.sv ====
// Top of the J/K GPIO bank: decoder, eight ports with pin muxes,
// read data return and the group pin change lines
`timescale 1ns/1ns
`default_nettype none
`include "gpio_defines.svh"

module gpio_bank (
   input  wire logic                   clk,
   input  wire logic                   reset,
   // Data-memory bus
   input  wire gpio_pkg::dm_bus_t      dm,
   output gpio_pkg::data_t             dbus_out,
   output logic                        io_out_en,
   // Crossbar side
   input  wire gpio_pkg::xb_ctl_t      xb [`GPIO_NUM_PORTS],
   output gpio_pkg::pin_vec_t          xb_pinx [`GPIO_NUM_PORTS],
   // Pads
   input  wire gpio_pkg::pin_vec_t     pad_in [`GPIO_NUM_PORTS],
   output gpio_pkg::pad_drive_t        pad [`GPIO_NUM_PORTS],
   // Pin change lines, one per group
   output logic [`GPIO_NUM_GROUPS-1:0] pcint
);

   gpio_pkg::reg_strobe_t      strobe;                       // Decoded access
   gpio_pkg::port_drive_t      drive [`GPIO_NUM_PORTS];      // Regs to mux
   gpio_pkg::data_t            rdata [`GPIO_NUM_PORTS];      // Regs to readback
   logic [`GPIO_NUM_PORTS-1:0] pcifr_set;                    // Per-port flag

   // ----------------------------------------------------------------------
   // Address decode
   // ----------------------------------------------------------------------
   gpio_reg_decode decode_inst (
      .clk    (clk),
      .reset  (reset),
      .dm     (dm),
      .strobe (strobe)
   );

   // ----------------------------------------------------------------------
   // Ports, index 0..3 is J0..J3, 4..7 is K0..K3
   // ----------------------------------------------------------------------
   for (genvar i = 0; i < `GPIO_NUM_PORTS; i++) begin : g_port
      gpio_port_regs regs_inst (
         .clk       (clk),
         .reset     (reset),
         .wr        (strobe.wr[i]),
         .rd        (strobe.rd[i]),
         .kind      (strobe.kind),
         .wdata     (dm.wdata),
         .pad_in    (pad_in[i]),    // Raw pads, synchronised inside
         .drive     (drive[i]),
         .pinx      (xb_pinx[i]),
         .rdata     (rdata[i]),
         .pcifr_set (pcifr_set[i])
      );

      gpio_pin_mux mux_inst (
         .port (drive[i]),
         .xb   (xb[i]),
         .pad  (pad[i])
      );
   end

   // ----------------------------------------------------------------------
   // Read return
   // ----------------------------------------------------------------------
   gpio_readback readback_inst (
      .rd        (strobe.rd),
      .rdata     (rdata),
      .dbus_out  (dbus_out),
      .io_out_en (io_out_en)
   );

   // Group OR, bit 0 for J, bit 1 for K
   for (genvar g = 0; g < `GPIO_NUM_GROUPS; g++) begin : g_group
      assign pcint[g] =
         |pcifr_set[g*`GPIO_PORTS_PER_GROUP +: `GPIO_PORTS_PER_GROUP];
   end

endmodule
`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// Testbench clock and synchronous reset source
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic reset
);

   localparam int HALF_PERIOD  = 20;  // 40 ns clock
   localparam int RESET_CYCLES = 8;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Release on a falling edge, clear of the sampling edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule
`default_nettype wire

// ==== tests/gpio_bank_tb.sv ====
// Testbench for the GPIO bank: bus tasks, register and pad model,
// concurrent checks against the model, watchdog and summary
`timescale 1ns/1ns
`default_nettype none
`include "gpio_defines.svh"

module gpio_bank_tb;

   localparam int NP            = `GPIO_NUM_PORTS;
   localparam int CLK_PERIOD    = 40;
   localparam int N_RAND_WR     = 40;
   localparam int N_PIN_ROUNDS  = 12;
   localparam int N_XB_ROUNDS   = 24;
   // Each bus access costs two cycles
   localparam int RUN_CYCLES =
      10 + 8*NP                     // Reset, then full readback
      + 2*N_RAND_WR + 8*NP          // Random writes and readback
      + 5*N_PIN_ROUNDS + 4*NP       // Pad rounds and PIN toggles
      + N_XB_ROUNDS + 1             // Crossbar rounds
      + 2*NP + 22                   // Mask setup and change waits
      + 16 + 8*NP;                  // Stray accesses and readback
   localparam int MARGIN_CYCLES = 100;

   logic                        clk;
   logic                        reset;
   gpio_pkg::dm_bus_t           dm;
   gpio_pkg::data_t             dbus_out;
   logic                        io_out_en;
   gpio_pkg::xb_ctl_t           xb [NP];
   gpio_pkg::pin_vec_t          xb_pinx [NP];
   gpio_pkg::pin_vec_t          pad_in [NP];
   gpio_pkg::pad_drive_t        pad [NP];
   logic [`GPIO_NUM_GROUPS-1:0] pcint;

   // Reference model
   gpio_pkg::pin_vec_t          m_ddr [NP];
   gpio_pkg::pin_vec_t          m_port [NP];
   gpio_pkg::pin_vec_t          m_msk [NP];
   gpio_pkg::pin_vec_t          msk_d [NP];     // Mask one edge late
   gpio_pkg::pin_vec_t          hist [4][NP];   // pad_in at last 4 edges
   gpio_pkg::pad_drive_t        exp_pad [NP];
   logic [`GPIO_NUM_GROUPS-1:0] exp_pcint;
   logic                        rd_check;       // Mapped read on the bus
   gpio_pkg::data_t             exp_rdata;

   string test_name;
   int    errors;
   int    tests_run;
   int    test_err_start;

   tb_clock_gen clkgen (.clk(clk), .reset(reset));

   gpio_bank dut0 (
      .clk       (clk),
      .reset     (reset),
      .dm        (dm),
      .dbus_out  (dbus_out),
      .io_out_en (io_out_en),
      .xb        (xb),
      .xb_pinx   (xb_pinx),
      .pad_in    (pad_in),
      .pad       (pad),
      .pcint     (pcint)
   );

   // ----------------------------------------------------------------------
   // Model of pad history and expected outputs
   // ----------------------------------------------------------------------
   always @(posedge clk) begin
      for (int i = 0; i < NP; i++) begin
         hist[0][i] <= pad_in[i];   // [0] is the newest sample
         hist[1][i] <= hist[0][i];
         hist[2][i] <= hist[1][i];
         hist[3][i] <= hist[2][i];
         msk_d[i]   <= m_msk[i];
      end
   end

   always_comb begin
      exp_pcint = '0;
      for (int i = 0; i < NP; i++) begin
         // Change seen 3 edges back, under the mask of one edge back
         if (((hist[2][i] ^ hist[3][i]) & msk_d[i]) != '0) begin
            exp_pcint[i / `GPIO_PORTS_PER_GROUP] = 1'b1;
         end
         for (int b = 0; b < `GPIO_PORT_WIDTH; b++) begin
            exp_pad[i].oe[b]  = xb[i].ddoe[b] ? xb[i].ddov[b] : m_ddr[i][b];
            exp_pad[i].out[b] = xb[i].pvoe[b] ? xb[i].pvov[b] : m_port[i][b];
         end
      end
   end

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------
   a_read_data: assert property (@(posedge clk) disable iff (reset)
      rd_check |-> dbus_out == exp_rdata)
      else begin
         errors++;
         $display("Error: %s read data expected %h actual %h",
                  test_name, $sampled(exp_rdata), $sampled(dbus_out));
      end

   a_out_en: assert property (@(posedge clk) disable iff (reset)
      io_out_en == rd_check)
      else begin
         errors++;
         $display("Error: %s io_out_en expected %b actual %b",
                  test_name, $sampled(rd_check), $sampled(io_out_en));
      end

   a_pcint: assert property (@(posedge clk) disable iff (reset)
      pcint == exp_pcint)
      else begin
         errors++;
         $display("Error: %s pcint expected %b actual %b",
                  test_name, $sampled(exp_pcint), $sampled(pcint));
      end

   for (genvar i = 0; i < NP; i++) begin : g_port_chk
      a_pad: assert property (@(posedge clk) disable iff (reset)
         pad[i] == exp_pad[i])
         else begin
            errors++;
            $display("Error: %s pad[%0d] expected %h actual %h",
                     test_name, i, $sampled(exp_pad[i]), $sampled(pad[i]));
         end

      a_pinx: assert property (@(posedge clk) disable iff (reset)
         xb_pinx[i] == hist[1][i])      // Two edges after the pad
         else begin
            errors++;
            $display("Error: %s xb_pinx[%0d] expected %h actual %h",
                     test_name, i, $sampled(hist[1][i]), $sampled(xb_pinx[i]));
         end
   end

   // ----------------------------------------------------------------------
   // Bus tasks
   // ----------------------------------------------------------------------
   function automatic gpio_pkg::addr_t reg_addr(input int p, input gpio_pkg::reg_kind_t k);
      return gpio_pkg::addr_t'(`GPIO_BASE_ADDR + 4 * p + int'(k));
   endfunction

   function automatic gpio_pkg::data_t model_reg(input int p, input gpio_pkg::reg_kind_t k);
      case (k)
         `GPIO_REG_PIN:  return hist[1][p];
         `GPIO_REG_DDR:  return m_ddr[p];
         `GPIO_REG_PORT: return m_port[p];
         default:        return m_msk[p];
      endcase
   endfunction

   // One access on the next falling edge, bus idle after it
   task automatic bus_cycle(input gpio_pkg::addr_t addr, input gpio_pkg::data_t wdata,
                            input logic re, input logic we, input logic sel);
      @(negedge clk);
      dm.addr  = addr;
      dm.wdata = wdata;
      dm.re    = re;
      dm.we    = we;
      dm.sel   = sel;
      @(negedge clk);
      dm = '0;
   endtask

   task automatic write_reg(input int p, input gpio_pkg::reg_kind_t k,
                            input gpio_pkg::data_t d);
      bus_cycle(reg_addr(p, k), d, 1'b0, 1'b1, 1'b1);
      case (k)                          // Model moves after the DUT edge
         `GPIO_REG_PIN:  m_port[p] = m_port[p] ^ d;
         `GPIO_REG_DDR:  m_ddr[p]  = d;
         `GPIO_REG_PORT: m_port[p] = d;
         default:        m_msk[p]  = d;
      endcase
   endtask

   task automatic read_reg(input int p, input gpio_pkg::reg_kind_t k);
      @(negedge clk);
      dm.addr   = reg_addr(p, k);
      dm.wdata  = '0;
      dm.re     = 1'b1;
      dm.we     = 1'b0;
      dm.sel    = 1'b1;
      rd_check  = 1'b1;
      exp_rdata = model_reg(p, k);
      @(negedge clk);
      dm       = '0;
      rd_check = 1'b0;
   endtask

   task automatic read_all();
      for (int p = 0; p < NP; p++) begin
         for (int k = 0; k < 4; k++) begin
            read_reg(p, gpio_pkg::reg_kind_t'(k));
         end
      end
   endtask

   task automatic begin_test(input string name);
      test_name      = name;
      test_err_start = errors;
   endtask

   task automatic end_test();
      tests_run++;
      $display("Test %-14s done, %0d error(s)", test_name, errors - test_err_start);
   endtask

   // ----------------------------------------------------------------------
   // Watchdog
   // ----------------------------------------------------------------------
   initial begin
      #((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the run did not complete",
               RUN_CYCLES + MARGIN_CYCLES);
      $display("Finished with errors");
      $finish;
   end

   // ----------------------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------------------
   initial begin
      gpio_pkg::reg_kind_t k;
      int p;

      dm        = '0;
      rd_check  = 1'b0;
      exp_rdata = '0;
      errors    = 0;
      tests_run = 0;
      for (int i = 0; i < NP; i++) begin
         xb[i]     = '0;
         pad_in[i] = '0;
         m_ddr[i]  = '0;
         m_port[i] = '0;
         m_msk[i]  = '0;
      end
      void'($urandom(32'h6a1b3eb7));
      wait (reset === 1'b0);

      begin_test("reset_state");
      read_all();                       // Everything reads back zero
      end_test();

      begin_test("reg_rw");
      repeat (N_RAND_WR) begin
         p = $urandom_range(NP - 1);
         k = gpio_pkg::reg_kind_t'($urandom_range(3, 1));  // DDR, PORT or MSK
         write_reg(p, k, gpio_pkg::data_t'($urandom));
      end
      read_all();
      end_test();

      begin_test("pin_sample");
      repeat (N_PIN_ROUNDS) begin
         @(negedge clk);
         for (int i = 0; i < NP; i++) begin
            pad_in[i] = gpio_pkg::pin_vec_t'($urandom);
         end
         p = $urandom_range(NP - 1);
         read_reg(p, `GPIO_REG_PIN);    // One edge in, still old value
         read_reg(p, `GPIO_REG_PIN);    // New value by now
      end
      for (int i = 0; i < NP; i++) begin
         write_reg(i, `GPIO_REG_PIN, gpio_pkg::data_t'($urandom));
         read_reg(i, `GPIO_REG_PORT);
      end
      end_test();

      begin_test("crossbar");
      repeat (N_XB_ROUNDS) begin
         @(negedge clk);
         for (int i = 0; i < NP; i++) begin
            xb[i] = gpio_pkg::xb_ctl_t'($urandom);
         end
      end
      @(negedge clk);
      for (int i = 0; i < NP; i++) begin
         xb[i] = '0;
      end
      end_test();

      begin_test("pin_change");
      for (int i = 0; i < NP; i++) begin
         write_reg(i, `GPIO_REG_MSK, (i == 1) ? 8'h10 : (i == 6) ? 8'h01 : 8'h00);
      end
      repeat (4) @(negedge clk);        // Let the pad history settle
      pad_in[1][4] = ~pad_in[1][4];     // J1 masked pin, group J
      repeat (6) @(negedge clk);
      pad_in[6][0] = ~pad_in[6][0];     // K2 masked pin, group K
      repeat (6) @(negedge clk);
      pad_in[1][3] = ~pad_in[1][3];     // Unmasked pins, no pulse
      pad_in[2]    = ~pad_in[2];
      pad_in[5]    = ~pad_in[5];
      repeat (6) @(negedge clk);
      end_test();

      begin_test("out_of_range");
      bus_cycle(8'h8F, gpio_pkg::data_t'($urandom), 1'b0, 1'b1, 1'b1);
      bus_cycle(8'hB0, gpio_pkg::data_t'($urandom), 1'b0, 1'b1, 1'b1);
      bus_cycle(gpio_pkg::addr_t'($urandom_range(8'h8F, 0)), 8'hFF, 1'b0, 1'b1, 1'b1);
      bus_cycle(gpio_pkg::addr_t'($urandom_range(8'hFF, 8'hB0)), 8'hFF, 1'b0, 1'b1, 1'b1);
      bus_cycle(8'h8F, '0, 1'b1, 1'b0, 1'b1);
      bus_cycle(8'hB0, '0, 1'b1, 1'b0, 1'b1);
      bus_cycle(reg_addr(3, `GPIO_REG_PORT), 8'h5A, 1'b0, 1'b1, 1'b0);  // sel low
      bus_cycle(reg_addr(3, `GPIO_REG_PORT), '0, 1'b1, 1'b0, 1'b0);
      read_all();                       // Model untouched, so no change
      end_test();

      $display("Tests run: %0d, errors: %0d", tests_run, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule
`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/gpio_pkg.sv
source/gpio_reg_decode.sv
source/gpio_port_regs.sv
source/gpio_pin_mux.sv
source/gpio_readback.sv
source/gpio_bank.sv
tests/tb_clock_gen.sv
tests/gpio_bank_tb.sv

// ==== Bender.yml ====
package:
  name: gpio_bank

export_include_dirs:
  - source

sources:
  - source/gpio_pkg.sv
  - source/gpio_reg_decode.sv
  - source/gpio_port_regs.sv
  - source/gpio_pin_mux.sv
  - source/gpio_readback.sv
  - source/gpio_bank.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/gpio_bank_tb.sv
